//--- rtl/icache_pkg.sv
package icache_pkg;

	localparam int ADDR_W = 64;
	localparam int WORD_W = 64;
	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 64;
	localparam int BEATS_PER_LINE = 4;
	localparam int BYTE_OFF_W = 3;                  // 8 bytes per fetch word
	localparam int BEAT_W = $clog2(BEATS_PER_LINE);
	localparam int INDEX_W = $clog2(NUM_SETS);
	localparam int BEAT_LSB = BYTE_OFF_W;           // addr[4:3]
	localparam int INDEX_LSB = BEAT_LSB + BEAT_W;   // addr[10:5]
	localparam int TAG_LSB = INDEX_LSB + INDEX_W;   // addr[63:11]
	localparam int TAG_W = ADDR_W - TAG_LSB;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL,
		RESPOND
	} ctrl_state_t;

	// address field helpers
	function automatic tag_t addr_tag(input addr_t a);
		return a[ADDR_W-1:TAG_LSB];
	endfunction

	function automatic index_t addr_index(input addr_t a);
		return a[INDEX_LSB +: INDEX_W];
	endfunction

	function automatic beat_t addr_beat(input addr_t a);
		return a[BEAT_LSB +: BEAT_W];
	endfunction

	function automatic addr_t line_align(input addr_t a);
		return {a[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}}; // drop offset within line
	endfunction

endpackage

//--- rtl/tag_lookup_if.sv
`timescale 1ns/1ps

interface tag_lookup_if import icache_pkg::*; ();

	index_t index;
	tag_t tag;
	logic lookup;     // compare strobe
	logic fill;       // write tag into victim way
	logic flush;      // drop all valid bits
	logic hit;
	way_t hit_way;
	way_t victim_way; // way a miss in this set would take

	modport ctrl (
		output index, tag, lookup, fill, flush,
		input hit, hit_way, victim_way
	);

	modport tags (
		input index, tag, lookup, fill, flush,
		output hit, hit_way, victim_way
	);

endinterface

//--- rtl/refill_if.sv
`timescale 1ns/1ps

interface refill_if import icache_pkg::*; ();

	logic start;      // one pulse per miss
	addr_t line_addr; // latched request address
	way_t way;
	index_t index;
	logic beat_we;
	beat_t beat_idx;
	word_t beat_data;
	logic done;       // comes with the last beat

	modport ctrl (
		output start, line_addr, way, index,
		input done
	);

	modport refill (
		input start, line_addr,
		output beat_we, beat_idx, beat_data, done
	);

	modport data (
		input way, index, beat_we, beat_idx, beat_data
	);

endinterface

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
	input logic clk,
	input logic rst_n,
	input addr_t cpu_req_addr,
	input logic cpu_req_valid,
	input logic flush,
	output logic cpu_ready,
	tag_lookup_if.ctrl tl,
	refill_if.ctrl rf,
	output logic rd_en,
	output way_t rd_way
);

	ctrl_state_t state_q;
	ctrl_state_t state_nxt;
	addr_t req_addr_q;
	way_t victim_q;
	logic take_req;

	assign take_req = (state_q == IDLE) && cpu_req_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_nxt;
		end
	end

	// request address held for the whole transaction
	always_ff @(posedge clk) begin
		if (take_req) begin
			req_addr_q <= cpu_req_addr;
		end
		if (rf.start) begin
			victim_q <= tl.victim_way; // set cannot change until the fill
		end
	end

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			IDLE: begin
				if (cpu_req_valid) begin
					state_nxt = LOOKUP;
				end
			end
			LOOKUP: begin
				if (tl.hit) begin
					state_nxt = RESPOND;
				end else begin
					state_nxt = REFILL;
				end
			end
			REFILL: begin
				if (rf.done) begin
					state_nxt = LOOKUP; // retry, now hits
				end
			end
			RESPOND: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	assign tl.index = addr_index(req_addr_q);
	assign tl.tag = addr_tag(req_addr_q);
	assign tl.lookup = (state_q == LOOKUP);
	assign tl.fill = (state_q == REFILL) && rf.done;
	// fence.i style flush, only when nothing is pending
	assign tl.flush = (state_q == IDLE) && flush && !cpu_req_valid;

	assign rf.start = (state_q == LOOKUP) && !tl.hit;
	assign rf.line_addr = req_addr_q;
	assign rf.index = addr_index(req_addr_q);
	assign rf.way = victim_q;

	assign rd_en = (state_q == LOOKUP) && tl.hit;
	assign rd_way = tl.hit_way;

	assign cpu_ready = (state_q == RESPOND); // data registered a cycle earlier

	a_ready_single: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |=> !cpu_ready);

	// only the first lookup of a request may refill
	a_start_from_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		rf.start |-> $past(state_q) == IDLE);

	// tag fill must land in the way the data store just wrote
	a_fill_way: assert property (@(posedge clk) disable iff (!rst_n)
		tl.fill |-> tl.victim_way == rf.way);

endmodule

//--- rtl/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array import icache_pkg::*; (
	input logic clk,
	input logic rst_n,
	tag_lookup_if.tags tl
);

	logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
	logic rr_q [NUM_SETS];              // next victim once the set is full
	tag_t tag_q [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0] set_valid;
	logic [NUM_WAYS-1:0] way_hit;

	assign set_valid = valid_q[tl.index];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = set_valid[w] && (tag_q[w][tl.index] == tl.tag);
		end
	end

	assign tl.hit = tl.lookup && (|way_hit);
	assign tl.hit_way = way_t'(way_hit[1]);

	// invalid way first, else round robin
	always_comb begin
		if (!set_valid[0]) begin
			tl.victim_way = way_t'(0);
		end else if (!set_valid[1]) begin
			tl.victim_way = way_t'(1);
		end else begin
			tl.victim_way = way_t'(rr_q[tl.index]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || tl.flush) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
				rr_q[s] <= 1'b0;
			end
		end else if (tl.fill) begin
			valid_q[tl.index][tl.victim_way] <= 1'b1;
			if (&set_valid) begin
				rr_q[tl.index] <= ~rr_q[tl.index]; // only advance on a real eviction
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tl.fill) begin
			tag_q[tl.victim_way][tl.index] <= tl.tag;
		end
	end

	a_one_way_hits: assert property (@(posedge clk) disable iff (!rst_n)
		tl.lookup |-> !(&way_hit));

endmodule

//--- rtl/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array import icache_pkg::*; (
	input logic clk,
	refill_if.data rf,
	input logic rd_en,
	input way_t rd_way,
	input index_t rd_index,
	input beat_t rd_beat,
	output word_t rd_data
);

	// one word per beat, 2 x 64 x 4
	word_t line_q [NUM_WAYS][NUM_SETS][BEATS_PER_LINE];

	always_ff @(posedge clk) begin
		if (rf.beat_we) begin
			line_q[rf.way][rf.index][rf.beat_idx] <= rf.beat_data;
		end
	end

	// registered read, data holds until the next hit
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= line_q[rd_way][rd_index][rd_beat];
		end
	end

endmodule

//--- rtl/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
	input logic clk,
	input logic rst_n,
	refill_if.refill rf,
	output addr_t mem_req_addr,
	output logic mem_req_valid,
	input word_t mem_data_read,
	input logic mem_ready
);

	logic busy_q;   // refill open, beats expected
	beat_t count_q;
	logic last_beat;

	assign last_beat = (count_q == beat_t'(BEATS_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			mem_req_valid <= 1'b0;
			count_q <= '0;
		end else if (rf.start) begin
			busy_q <= 1'b1;
			mem_req_valid <= 1'b1;
			count_q <= '0;
		end else if (rf.beat_we) begin
			mem_req_valid <= 1'b0; // request ends with beat 0
			count_q <= count_q + beat_t'(1);
			if (last_beat) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rf.start) begin
			mem_req_addr <= line_align(rf.line_addr);
		end
	end

	// beats pass straight through to the data store
	assign rf.beat_we = busy_q && mem_ready;
	assign rf.beat_idx = count_q;
	assign rf.beat_data = mem_data_read;
	assign rf.done = rf.beat_we && last_beat;

	a_ready_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ready |-> busy_q);

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
	input logic clk,
	input logic rst_n,
	input addr_t cpu_req_addr,
	input logic cpu_req_valid,
	input logic flush,
	output word_t cpu_data_read,
	output logic cpu_ready,
	output addr_t mem_req_addr,
	output logic mem_req_valid,
	input word_t mem_data_read,
	input logic mem_ready
);

	tag_lookup_if tl_if ();
	refill_if rf_if ();

	logic rd_en;
	way_t rd_way;

	icache_ctrl icache_ctrl_inst (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_req_addr (cpu_req_addr),
		.cpu_req_valid (cpu_req_valid),
		.flush (flush),
		.cpu_ready (cpu_ready),
		.tl (tl_if.ctrl),
		.rf (rf_if.ctrl),
		.rd_en (rd_en),
		.rd_way (rd_way)
	);

	icache_tag_array icache_tag_array_inst (
		.clk (clk),
		.rst_n (rst_n),
		.tl (tl_if.tags)
	);

	// read set and word come from the latched request
	icache_data_array icache_data_array_inst (
		.clk (clk),
		.rf (rf_if.data),
		.rd_en (rd_en),
		.rd_way (rd_way),
		.rd_index (addr_index(rf_if.line_addr)),
		.rd_beat (addr_beat(rf_if.line_addr)),
		.rd_data (cpu_data_read)
	);

	icache_refill icache_refill_inst (
		.clk (clk),
		.rst_n (rst_n),
		.rf (rf_if.refill),
		.mem_req_addr (mem_req_addr),
		.mem_req_valid (mem_req_valid),
		.mem_data_read (mem_data_read),
		.mem_ready (mem_ready)
	);

endmodule

//--- sim/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

	localparam logic [63:0] MEM_PATTERN = 64'h5a5a_0f0f_c3c3_3c3c;
	localparam logic [31:0] LFSR_SEED = 32'h8d46;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
	localparam int NUM_RANDOM = 40;
	localparam int NUM_DIRECTED = 11;
	localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 80;

	logic clk;
	logic rst_n;
	logic [63:0] cpu_req_addr;
	logic cpu_req_valid;
	logic flush;
	logic [63:0] cpu_data_read;
	logic cpu_ready;
	logic [63:0] mem_req_addr;
	logic mem_req_valid;
	logic [63:0] mem_data_read;
	logic mem_ready;

	// expectations for the request in flight
	logic [63:0] exp_data;
	logic [63:0] exp_line;
	logic exp_hit;
	logic req_first;        // high in the cycle whose closing edge samples a request
	logic started;
	string test_name;

	int lat = 0;            // edges since the sampling edge
	int mem_reqs = 0;       // rising edges of mem_req_valid in this request
	logic mem_valid_q = 1'b0;
	int resp_count = 0;
	int req_count = 0;
	int cycle_count = 0;

	// reference copy of the tag state
	logic ref_valid [64][2];
	logic [52:0] ref_tag [64][2];
	logic ref_rr [64];

	logic [31:0] addr_lfsr;
	logic [31:0] gap_lfsr;

	icache_top icache_top_inst (
		.clk (clk),
		.rst_n (rst_n),
		.cpu_req_addr (cpu_req_addr),
		.cpu_req_valid (cpu_req_valid),
		.flush (flush),
		.cpu_data_read (cpu_data_read),
		.cpu_ready (cpu_ready),
		.mem_req_addr (mem_req_addr),
		.mem_req_valid (mem_req_valid),
		.mem_data_read (mem_data_read),
		.mem_ready (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		mem_valid_q <= mem_req_valid;
		if (req_first) begin
			lat <= 1;
			mem_reqs <= 0;
		end else begin
			if (lat != 0) begin
				lat <= lat + 1;
			end
			if (mem_req_valid && !mem_valid_q) begin
				mem_reqs <= mem_reqs + 1;
			end
		end
		if (rst_n && cpu_ready) begin
			resp_count <= resp_count + 1;
		end
	end

	task automatic report_mismatch(input string check, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("CHECK FAILED %s / %s: expected %h, actual %h", test_name, check,
			expected, actual);
		$display("Verification failed");
		$fatal(1, "first mismatch ends the run");
	endtask

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !cpu_ready && !mem_req_valid)
		else report_mismatch("quiet after reset", 64'd0,
			64'({$sampled(cpu_ready), $sampled(mem_req_valid)}));

	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> cpu_data_read == exp_data)
		else report_mismatch("fetch data", $sampled(exp_data), $sampled(cpu_data_read));

	a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready && exp_hit |-> lat == 2)
		else report_mismatch("hit latency", 64'd2, 64'($sampled(lat)));

	// hit or miss as the victim rule predicts
	a_mem_req_count: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> mem_reqs == (exp_hit ? 0 : 1))
		else report_mismatch("memory requests", $sampled(exp_hit) ? 64'd0 : 64'd1,
			64'($sampled(mem_reqs)));

	a_mem_addr: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |-> mem_req_addr == exp_line)
		else report_mismatch("refill address", $sampled(exp_line), $sampled(mem_req_addr));

	a_mem_timing: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid && !mem_valid_q |-> lat == 2)
		else report_mismatch("refill request timing", 64'd2, 64'($sampled(lat)));

	// one galois shift of the lfsr
	function automatic logic [31:0] galois_step(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? LFSR_TAPS : 32'h0);
	endfunction

	// galois step per bit taken
	task automatic draw_bits(inout logic [31:0] state, input int n,
			output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			value = {value[30:0], state[0]};
			state = galois_step(state);
		end
	endtask

	function automatic logic [52:0] pick_tag(input logic [1:0] sel);
		case (sel)
			2'd0: return 53'h0_0000_0000_0001;
			2'd1: return 53'h0_0000_0004_2a17;
			2'd2: return 53'h1_f3c0_0000_0b00;
			default: return 53'h0_8d46_1234_5678;
		endcase
	endfunction

	function automatic logic [5:0] pick_index(input logic [1:0] sel);
		case (sel)
			2'd0: return 6'd3;
			2'd1: return 6'd17;
			2'd2: return 6'd42;
			default: return 6'd63;
		endcase
	endfunction

	function automatic logic [63:0] make_addr(input logic [1:0] tag_sel,
			input logic [5:0] index, input logic [1:0] beat);
		return {pick_tag(tag_sel), index, beat, 3'b000};
	endfunction

	task automatic clear_model();
		int s;
		for (s = 0; s < 64; s++) begin
			ref_valid[s][0] = 1'b0;
			ref_valid[s][1] = 1'b0;
			ref_rr[s] = 1'b0;
		end
	endtask

	// invalid way first, then round robin on a full set
	task automatic predict(input logic [63:0] addr, output logic hit);
		logic [5:0] idx;
		logic [52:0] tag;
		logic victim;
		idx = addr[10:5];
		tag = addr[63:11];
		hit = (ref_valid[idx][0] && ref_tag[idx][0] == tag)
			|| (ref_valid[idx][1] && ref_tag[idx][1] == tag);
		if (!hit) begin
			if (!ref_valid[idx][0]) begin
				victim = 1'b0;
			end else if (!ref_valid[idx][1]) begin
				victim = 1'b1;
			end else begin
				victim = ref_rr[idx];
				ref_rr[idx] = !ref_rr[idx];
			end
			ref_valid[idx][victim] = 1'b1;
			ref_tag[idx][victim] = tag;
		end
	endtask

	task automatic fetch(input logic [63:0] addr);
		logic hit;
		predict(addr, hit);
		exp_line = {addr[63:5], 5'b0};
		exp_data = {addr[63:3], 3'b0} ^ MEM_PATTERN;
		exp_hit = hit;
		cpu_req_addr = addr;
		cpu_req_valid = 1'b1;
		req_first = 1'b1;
		started = 1'b1;
		req_count++;
		@(posedge clk);
		#1;
		req_first = 1'b0;
		do begin
			@(negedge clk); // mid cycle, away from the edges
		end while (!cpu_ready);
		@(posedge clk);
		#1;
		cpu_req_valid = 1'b0;
	endtask

	task automatic flush_cache();
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		clear_model();
	endtask

	initial begin : stimulus
		logic [31:0] tsel;
		logic [31:0] isel;
		logic [31:0] bsel;
		int n;
		rst_n = 1'b0;
		cpu_req_addr = '0;
		cpu_req_valid = 1'b0;
		flush = 1'b0;
		req_first = 1'b0;
		started = 1'b0;
		exp_hit = 1'b0;
		exp_data = '0;
		exp_line = '0;
		test_name = "reset";
		addr_lfsr = LFSR_SEED;
		clear_model();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (8) @(posedge clk);
		#1;

		test_name = "random";
		for (n = 0; n < NUM_RANDOM; n++) begin
			draw_bits(addr_lfsr, 2, tsel);
			draw_bits(addr_lfsr, 2, isel);
			draw_bits(addr_lfsr, 2, bsel);
			fetch(make_addr(tsel[1:0], pick_index(isel[1:0]), bsel[1:0]));
		end

		test_name = "replacement"; // three tags fight over set 9
		fetch(make_addr(2'd0, 6'd9, 2'd0));
		fetch(make_addr(2'd1, 6'd9, 2'd1));
		fetch(make_addr(2'd2, 6'd9, 2'd2));
		fetch(make_addr(2'd0, 6'd9, 2'd0));
		fetch(make_addr(2'd2, 6'd9, 2'd3));
		fetch(make_addr(2'd1, 6'd9, 2'd1));
		fetch(make_addr(2'd0, 6'd9, 2'd2));

		test_name = "flush";
		fetch(make_addr(2'd3, 6'd20, 2'd3));
		fetch(make_addr(2'd3, 6'd20, 2'd1));
		flush_cache();
		fetch(make_addr(2'd3, 6'd20, 2'd3));
		fetch(make_addr(2'd0, 6'd9, 2'd0));

		test_name = "summary";
		repeat (4) @(posedge clk);
		if (resp_count == req_count) begin
			$display("%0d requests served", req_count);
			$display("Verification passed");
			$finish;
		end else begin
			report_mismatch("response count", 64'(req_count), 64'(resp_count));
		end
	end

	// line memory, random idle gaps before each beat
	initial begin : memory
		logic [63:0] line;
		logic [31:0] gap;
		int b;
		mem_ready = 1'b0;
		mem_data_read = '0;
		gap_lfsr = LFSR_SEED;
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && mem_req_valid) begin
				line = mem_req_addr;
				for (b = 0; b < 4; b++) begin
					draw_bits(gap_lfsr, 2, gap);
					repeat (gap) begin
						@(posedge clk);
						#1;
					end
					mem_ready = 1'b1;
					mem_data_read = (line + 64'(b * 8)) ^ MEM_PATTERN;
					@(posedge clk);
					#1;
					mem_ready = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$fatal(1, "timeout");
	end

endmodule

//--- src.f
rtl/icache_pkg.sv
rtl/tag_lookup_if.sv
rtl/refill_if.sv
rtl/icache_ctrl.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_refill.sv
rtl/icache_top.sv
sim/tb_icache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = tb_icache
FILELIST = src.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
